// File: src.f
bridgePkg.sv
ahbSlaveIf.sv
apbFsmController.sv
apbRegBank.sv
ahbApbSystem.sv
apbFsm_props.sv
tbTop.sv

// File: tbTop.sv
`timescale 1ns/1ps
`default_nettype none

module tbTop;
	import bridgePkg::*;

	logic Hclk;
	logic Hresetn;
	logic Hwrite;
	logic [1:0] Htrans;
	addr_t Haddr;
	data_t Hwdata;
	wire Hreadyin;
	logic Hreadyout;
	data_t Hrdata;
	logic [1:0] Hresp;
	addr_t Paddr;
	data_t Pwdata;
	logic Pwrite;
	sel_t Pselx;
	logic Penable;

	logic [31:0] lfsrState;
	data_t model [numSlaves][bankWords];
	addr_t qAddr [$];
	logic qWrite [$];
	logic [1:0] qTrans [$];
	data_t qData [$];
	data_t readData [$];
	data_t expected [$];
	int errors = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int penableCount = 0;
	int writeCount = 0;
	int lowCount = 0;
	sel_t lastWriteSel;
	addr_t lastWriteAddr;
	data_t lastWriteData;

	assign Hreadyin = Hresetn ? Hreadyout : 1'b1;   // with a single master the ready is fed back.

	ahbApbSystem DUT (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Hwrite(Hwrite),
		.Hreadyin(Hreadyin),
		.Htrans(Htrans),
		.Haddr(Haddr),
		.Hwdata(Hwdata),
		.Hreadyout(Hreadyout),
		.Hrdata(Hrdata),
		.Hresp(Hresp),
		.Paddr(Paddr),
		.Pwdata(Pwdata),
		.Pwrite(Pwrite),
		.Pselx(Pselx),
		.Penable(Penable)
	);

	initial
	begin
		Hclk = 1'b0;
		forever #5 Hclk = ~Hclk;
	end

	// APB activity seen in the middle of each cycle.
	always @(negedge Hclk)
	begin
		if (Hresetn)
		begin
			if (Penable)
				penableCount++;
			if (Penable && Pwrite)
			begin
				writeCount++;
				lastWriteSel = Pselx;
				lastWriteAddr = Paddr;
				lastWriteData = Pwdata;
			end
			if (!Hreadyout)
				lowCount++;
		end
	end

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------

	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			bits = {bits[30:0], lfsrState[0]};
			lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'hD000_0001 : 32'h0);
		end
		return bits;
	endfunction

	// each peripheral window is 64 MB above the previous one.
	function automatic addr_t regAddr(input int bank, input int idx, input logic [19:0] upper);
		return slave0Base + addr_t'(bank) * 32'h0400_0000 + {6'b0, upper, idx[3:0], 2'b00};
	endfunction

	task automatic queueTransfer(input addr_t addr, input logic write, input logic [1:0] trans,
		input data_t data);
		qAddr.push_back(addr);
		qWrite.push_back(write);
		qTrans.push_back(trans);
		qData.push_back(data);
	endtask

	task automatic queueWrite(input int bank, input int idx, input data_t value,
		input logic [1:0] trans);
		queueTransfer(regAddr(bank, idx, '0), 1'b1, trans, value);
		model[bank][idx] = value;
	endtask

	task automatic queueRead(input int bank, input int idx);
		queueTransfer(regAddr(bank, idx, '0), 1'b0, htransNonseq, '0);
		expected.push_back(model[bank][idx]);
	endtask

	task automatic driveAddress(input int i);
		if (i < 0)
			Htrans <= htransIdle;
		else
		begin
			Haddr <= qAddr[i];
			Hwrite <= qWrite[i];
			Htrans <= qTrans[i];
		end
	endtask

	// AHB master that moves an address phase on at an edge where ready was high.
	task automatic runBus();
		int addrIdx;
		int dataIdx;
		int stall;
		logic ready;
		addrIdx = 0;
		dataIdx = -1;
		stall = 0;
		readData.delete();
		@(posedge Hclk);
		driveAddress(0);
		while ((addrIdx >= 0 || dataIdx >= 0) && stall <= 16)
		begin
			@(negedge Hclk);
			ready = Hreadyout;
			checkResp("Hresp", Hresp, 2'b00);
			if (ready && dataIdx >= 0 && !qWrite[dataIdx] && qTrans[dataIdx] != htransIdle)
				readData.push_back(Hrdata);
			stall = ready ? 0 : stall + 1;
			@(posedge Hclk);
			if (ready)
			begin
				dataIdx = addrIdx;
				addrIdx = (addrIdx >= 0 && addrIdx + 1 < qAddr.size()) ? addrIdx + 1 : -1;
				driveAddress(addrIdx);
				if (dataIdx >= 0 && qWrite[dataIdx])
					Hwdata <= qData[dataIdx];
			end
		end
		if (stall > 16)
			reportError("Hreadyout stayed low during a transfer");
		stall = 0;
		do
		begin
			@(negedge Hclk);
			stall++;
		end
		while (!(Hreadyout && !Penable && Pselx == '0) && stall < 16);
		if (stall >= 16)
			reportError("bridge did not return to idle");
		qAddr.delete();
		qWrite.delete();
		qTrans.delete();
		qData.delete();
	endtask

	// ----------------------------------------
	// checks
	// ----------------------------------------

	task automatic reportError(input string msg);
		$display("Error at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic checkData(input string name, input data_t got, input data_t exp);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkAddr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkSel(input string name, input sel_t got, input sel_t exp);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkResp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkReadback();
		checkCount("read data beats", readData.size(), expected.size());
		for (int i = 0; i < expected.size() && i < readData.size(); i++)
			checkData($sformatf("Hrdata beat %0d", i), readData[i], expected[i]);
		expected.delete();
	endtask

	task automatic readAllCheck();
		for (int b = 0; b < numSlaves; b++)
		begin
			for (int i = 0; i < bankWords; i++)
				queueRead(b, i);
		end
		runBus();
		checkReadback();
	endtask

	task automatic finishTest(input string name, input int startErrors);
		if (errors == startErrors)
		begin
			$display("%s: ok", name);
			testsPassed++;
		end
		else
		begin
			$display("%s: %0d errors", name, errors - startErrors);
			testsFailed++;
		end
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------

	task automatic resetTest();
		int start;
		int waitCycles;
		start = errors;
		for (int i = 0; i < 2; i++)
		begin
			@(negedge Hclk);
			checkBit("Hreadyout", Hreadyout, 1'b0);
			checkBit("Penable", Penable, 1'b0);
			checkBit("Pwrite", Pwrite, 1'b0);
			checkSel("Pselx", Pselx, '0);
		end
		@(posedge Hclk);
		Hresetn <= 1'b1;
		waitCycles = 0;
		do
		begin
			@(negedge Hclk);
			waitCycles++;
		end
		while (!Hreadyout && waitCycles < 2);
		checkBit("Hreadyout", Hreadyout, 1'b1);
		checkBit("Penable", Penable, 1'b0);
		checkBit("Pwrite", Pwrite, 1'b0);
		checkSel("Pselx", Pselx, '0);
		readAllCheck();
		finishTest("reset state", start);
	endtask

	task automatic singleWriteRead();
		int start;
		int idx;
		int writesBefore;
		logic [19:0] upper;
		data_t value;
		addr_t addr;
		start = errors;
		for (int b = 0; b < numSlaves; b++)
		begin
			idx = int'(takeBits(4));
			upper = 20'(takeBits(20));
			value = takeBits(32);
			addr = regAddr(b, idx, upper);   // upper bits alias onto the same register.
			writesBefore = writeCount;
			queueTransfer(addr, 1'b1, htransNonseq, value);
			runBus();
			model[b][idx] = value;
			checkCount("write accesses", writeCount - writesBefore, 1);
			checkSel("Pselx", lastWriteSel, sel_t'(1 << b));
			checkAddr("Paddr", lastWriteAddr, addr);
			checkData("Pwdata", lastWriteData, value);
			queueTransfer(addr, 1'b0, htransNonseq, '0);
			expected.push_back(model[b][idx]);
			runBus();
			checkReadback();
		end
		finishTest("single write and read", start);
	endtask

	task automatic writeBurst();
		int start;
		int base;
		int writesBefore;
		start = errors;
		base = int'(takeBits(4));
		writesBefore = writeCount;
		for (int i = 0; i < 4; i++)
			queueWrite(i % 3, (base + i) % 16, takeBits(32), i == 0 ? htransNonseq : htransSeq);
		runBus();
		checkCount("write accesses", writeCount - writesBefore, 4);
		for (int i = 0; i < 4; i++)
			queueRead(i % 3, (base + i) % 16);
		runBus();
		checkReadback();
		finishTest("write burst", start);
	endtask

	task automatic readBurst();
		int start;
		int banks [6];
		int idxs [6];
		start = errors;
		for (int i = 0; i < 6; i++)
		begin
			banks[i] = int'(takeBits(2)) % 3;
			idxs[i] = int'(takeBits(4));
			queueWrite(banks[i], idxs[i], takeBits(32), htransNonseq);
		end
		runBus();
		for (int i = 0; i < 6; i++)
			queueRead(banks[i], idxs[i]);
		runBus();
		checkReadback();
		finishTest("read burst", start);
	endtask

	task automatic ignoredTransfers();
		int start;
		int penableBefore;
		int lowBefore;
		start = errors;
		penableBefore = penableCount;
		lowBefore = lowCount;
		queueTransfer(mapEnd, 1'b1, htransNonseq, takeBits(32));
		queueTransfer(32'hFFFF_FFFC, 1'b1, htransNonseq, takeBits(32));
		queueTransfer(slave0Base - 4, 1'b1, htransNonseq, takeBits(32));
		queueTransfer(regAddr(1, int'(takeBits(4)), '0), 1'b1, htransIdle, takeBits(32));
		runBus();
		checkCount("Penable cycles", penableCount - penableBefore, 0);
		checkCount("Hreadyout low cycles", lowCount - lowBefore, 0);
		readAllCheck();
		finishTest("ignored transfers", start);
	endtask

	task automatic writeThenRead();
		int start;
		int idx;
		start = errors;
		for (int b = 0; b < numSlaves; b++)
		begin
			idx = int'(takeBits(4));
			queueWrite(b, idx, takeBits(32), htransNonseq);
			queueRead(b, idx);   // the read sits right behind the write.
			runBus();
			checkReadback();
		end
		finishTest("write then read", start);
	endtask

	initial
	begin
		lfsrState = 32'h347d1f26;
		Hresetn = 1'b0;
		Hwrite = 1'b0;
		Htrans = htransIdle;
		Haddr = '0;
		Hwdata = '0;
		for (int b = 0; b < numSlaves; b++)
		begin
			for (int i = 0; i < bankWords; i++)
				model[b][i] = '0;
		end
		resetTest();
		singleWriteRead();
		writeBurst();
		readBurst();
		ignoredTransfers();
		writeThenRead();
		if (DUT.apbFsm.props.assertFails != 0)
			reportError("APB phase assertions failed");
		$display("tests passed %0d, failed %0d", testsPassed, testsFailed);
		if (errors == 0 && testsFailed == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: apbFsm_props.sv
`timescale 1ns/1ps
`default_nettype none

module apbFsmProps (
	input logic                  Hclk,
	input logic                  Hresetn,
	input bridgePkg::apbState_t  state,
	input logic                  Penable,
	input logic                  Hreadyout,
	input bridgePkg::sel_t       Pselx,
	input bridgePkg::addr_t      Paddr
);
	import bridgePkg::*;

	int assertFails = 0;

	// ----------------------------------------
	// APB phase rules
	// ----------------------------------------

	setupBeforeAccess: assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |-> ($past(Pselx) != '0) && !$past(Penable) && (Pselx == $past(Pselx))
			&& (Paddr == $past(Paddr)))
		else
		begin
			$error("access cycle without a matching setup cycle");
			assertFails++;
		end

	selectOneHot: assert property (@(posedge Hclk) disable iff (!Hresetn) $onehot0(Pselx))
		else
		begin
			$error("more than one peripheral selected");
			assertFails++;
		end

	singleAccess: assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |=> !(Penable && (Paddr == $past(Paddr))))
		else
		begin
			$error("access cycle repeated on the same address");
			assertFails++;
		end

	// the first cycle out of reset still carries the reset value of Hreadyout.
	readyWhenIdle: assert property (@(posedge Hclk) disable iff (!Hresetn)
		(state == stIdle) && $past(Hresetn) |-> Hreadyout)
		else
		begin
			$error("Hreadyout low while the controller is idle");
			assertFails++;
		end

endmodule

bind apbFsmController apbFsmProps props (
	.Hclk(Hclk),
	.Hresetn(Hresetn),
	.state(state),
	.Penable(Penable),
	.Hreadyout(Hreadyout),
	.Pselx(Pselx),
	.Paddr(Paddr)
);

`default_nettype wire

// File: ahbApbSystem.sv
`timescale 1ns/1ps
`default_nettype none

module ahbApbSystem (
	input  logic             Hclk,
	input  logic             Hresetn,
	input  logic             Hwrite,
	input  logic             Hreadyin,
	input  logic [1:0]       Htrans,
	input  bridgePkg::addr_t Haddr,
	input  bridgePkg::data_t Hwdata,
	output logic             Hreadyout,
	output bridgePkg::data_t Hrdata,
	output logic [1:0]       Hresp,
	output bridgePkg::addr_t Paddr,
	output bridgePkg::data_t Pwdata,
	output logic             Pwrite,
	output bridgePkg::sel_t  Pselx,
	output logic             Penable
);
	import bridgePkg::*;

	logic valid;
	logic Hwritereg;
	addr_t Haddr1;
	addr_t Haddr2;
	data_t Hwdata1;
	data_t Hwdata2;
	data_t Prdata;
	sel_t tempselx;

	ahbSlaveIf ahbSlave (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Hwrite(Hwrite),
		.Hreadyin(Hreadyin),
		.Htrans(Htrans),
		.Haddr(Haddr),
		.Hwdata(Hwdata),
		.Prdata(Prdata),
		.valid(valid),
		.Hwritereg(Hwritereg),
		.Haddr1(Haddr1),
		.Haddr2(Haddr2),
		.Hwdata1(Hwdata1),
		.Hwdata2(Hwdata2),
		.tempselx(tempselx),
		.Hrdata(Hrdata),
		.Hresp(Hresp)
	);

	apbFsmController apbFsm (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.valid(valid),
		.Hwrite(Hwrite),
		.Hwritereg(Hwritereg),
		.Haddr(Haddr),
		.Haddr1(Haddr1),
		.Haddr2(Haddr2),
		.Hwdata(Hwdata),
		.Hwdata1(Hwdata1),
		.Hwdata2(Hwdata2),
		.Prdata(Prdata),
		.tempselx(tempselx),
		.Pwrite(Pwrite),
		.Penable(Penable),
		.Hreadyout(Hreadyout),
		.Pselx(Pselx),
		.Paddr(Paddr),
		.Pwdata(Pwdata)
	);

	apbRegBank regBank (
		.Hclk(Hclk),
		.Hresetn(Hresetn),
		.Pwrite(Pwrite),
		.Penable(Penable),
		.Pselx(Pselx),
		.Paddr(Paddr),
		.Pwdata(Pwdata),
		.Prdata(Prdata)
	);

endmodule

`default_nettype wire

// File: apbRegBank.sv
`timescale 1ns/1ps
`default_nettype none

module apbRegBank (
	input  logic             Hclk,
	input  logic             Hresetn,
	input  logic             Pwrite,
	input  logic             Penable,
	input  bridgePkg::sel_t  Pselx,
	input  bridgePkg::addr_t Paddr,
	input  bridgePkg::data_t Pwdata,
	output bridgePkg::data_t Prdata
);
	import bridgePkg::*;

	data_t regs [numSlaves][bankWords];
	logic [wordIdxWidth-1:0] wordIdx;

	assign wordIdx = Paddr[2 +: wordIdxWidth];   // word addressing, byte lanes ignored.

	// ----------------------------------------
	// write at the access cycle
	// ----------------------------------------

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			for (int s = 0; s < numSlaves; s++)
			begin
				for (int w = 0; w < bankWords; w++)
					regs[s][w] <= '0;
			end
		end
		else if (Penable && Pwrite)
		begin
			for (int s = 0; s < numSlaves; s++)
			begin
				if (Pselx[s])
					regs[s][wordIdx] <= Pwdata;
			end
		end
	end

	// ----------------------------------------
	// read mux
	// ----------------------------------------

	always_comb
	begin
		Prdata = '0;
		for (int s = 0; s < numSlaves; s++)
		begin
			if (Pselx[s])
				Prdata = regs[s][wordIdx];   // Pselx is one-hot, so at most one hit.
		end
	end

endmodule

`default_nettype wire

// File: apbFsmController.sv
`timescale 1ns/1ps
`default_nettype none

module apbFsmController (
	input  logic             Hclk,
	input  logic             Hresetn,
	input  logic             valid,
	input  logic             Hwrite,
	input  logic             Hwritereg,
	input  bridgePkg::addr_t Haddr,
	input  bridgePkg::addr_t Haddr1,
	input  bridgePkg::addr_t Haddr2,
	input  bridgePkg::data_t Hwdata,
	input  bridgePkg::data_t Hwdata1,
	input  bridgePkg::data_t Hwdata2,
	input  bridgePkg::data_t Prdata,
	input  bridgePkg::sel_t  tempselx,
	output logic             Pwrite,
	output logic             Penable,
	output logic             Hreadyout,
	output bridgePkg::sel_t  Pselx,
	output bridgePkg::addr_t Paddr,
	output bridgePkg::data_t Pwdata
);
	import bridgePkg::*;

	apbState_t state;
	apbState_t nextState;
	logic pwriteNext;
	logic penableNext;
	logic hreadyoutNext;
	sel_t pselxNext;
	addr_t paddrNext;
	data_t pwdataNext;

	// ----------------------------------------
	// state sequencing
	// ----------------------------------------

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			state <= stIdle;
		else
			state <= nextState;
	end

	always_comb
	begin
		case (state)
			stIdle, stRenable, stWenable:
				if (valid && Hwrite)
					nextState = stWwait;
				else if (valid)
					nextState = stRead;
				else
					nextState = stIdle;
			stWwait:
				nextState = valid ? stWriteP : stWrite;
			stRead:
				nextState = stRenable;
			stWrite:
				nextState = valid ? stWenableP : stWenable;
			stWriteP:
				nextState = stWenableP;
			stWenableP:
				if (Hwritereg)
					nextState = valid ? stWriteP : stWrite;
				else
					nextState = stRead;   // the transfer queued behind the write is a read.
			default:
				nextState = stIdle;
		endcase
	end

	// ----------------------------------------
	// registered APB and ready outputs
	// ----------------------------------------

	always_comb
	begin
		pselxNext = '0;
		penableNext = 1'b0;
		hreadyoutNext = 1'b1;
		pwriteNext = Pwrite;
		paddrNext = Paddr;
		pwdataNext = Pwdata;
		case (state)
			stIdle, stRenable, stWenable:
			begin
				if (valid && !Hwrite)
				begin
					paddrNext = Haddr;   // read setup straight from the address phase.
					pwriteNext = 1'b0;
					pselxNext = tempselx;
					hreadyoutNext = 1'b0;
				end
			end
			stWwait:
			begin
				paddrNext = Haddr1;
				pwdataNext = Hwdata;   // write data is on the bus this cycle.
				pwriteNext = 1'b1;
				pselxNext = selDecode(Haddr1);
				hreadyoutNext = 1'b0;
			end
			stRead:
			begin
				pselxNext = Pselx;
				penableNext = 1'b1;
			end
			stWrite:
			begin
				paddrNext = Haddr1;
				pwdataNext = Hwdata1;
				pselxNext = Pselx;
				penableNext = 1'b1;
			end
			stWriteP:
			begin
				paddrNext = Haddr2;   // the newer transfer already sits in Haddr1.
				pwdataNext = Hwdata2;
				pselxNext = Pselx;
				penableNext = 1'b1;
				hreadyoutNext = Hwritereg;   // a queued read holds the master off.
			end
			stWenableP:
			begin
				paddrNext = Haddr1;
				pwdataNext = Hwdata;
				pwriteNext = Hwritereg;
				pselxNext = selDecode(Haddr1);
				hreadyoutNext = 1'b0;
			end
			default:
				hreadyoutNext = 1'b1;
		endcase
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			Paddr <= '0;
			Pwdata <= '0;
			Pwrite <= 1'b0;
			Pselx <= '0;
			Penable <= 1'b0;
			Hreadyout <= 1'b0;
		end
		else
		begin
			Paddr <= paddrNext;
			Pwdata <= pwdataNext;
			Pwrite <= pwriteNext;
			Pselx <= pselxNext;
			Penable <= penableNext;
			Hreadyout <= hreadyoutNext;
		end
	end

endmodule

`default_nettype wire

// File: ahbSlaveIf.sv
`timescale 1ns/1ps
`default_nettype none

module ahbSlaveIf (
	input  logic             Hclk,
	input  logic             Hresetn,
	input  logic             Hwrite,
	input  logic             Hreadyin,
	input  logic [1:0]       Htrans,
	input  bridgePkg::addr_t Haddr,
	input  bridgePkg::data_t Hwdata,
	input  bridgePkg::data_t Prdata,
	output logic             valid,
	output logic             Hwritereg,
	output bridgePkg::addr_t Haddr1,
	output bridgePkg::addr_t Haddr2,
	output bridgePkg::data_t Hwdata1,
	output bridgePkg::data_t Hwdata2,
	output bridgePkg::sel_t  tempselx,
	output bridgePkg::data_t Hrdata,
	output logic [1:0]       Hresp
);
	import bridgePkg::*;

	logic activeTrans;

	// ----------------------------------------
	// address phase decode
	// ----------------------------------------

	assign activeTrans = (Htrans == htransNonseq) || (Htrans == htransSeq);
	assign tempselx = selDecode(Haddr);
	assign valid = Hreadyin && activeTrans && (tempselx != '0);   // busy and idle are dropped here.

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			Hwritereg <= 1'b0;
		else if (valid)
			Hwritereg <= Hwrite;   // direction of the newest accepted transfer.
	end

	// ----------------------------------------
	// address and write data pipelines
	// ----------------------------------------

	always_ff @(posedge Hclk)
	begin
		if (valid)
		begin
			Haddr1 <= Haddr;
			Haddr2 <= Haddr1;
		end
	end

	// write data lands one cycle after its address, so a new accept means
	// the bus holds the data of the transfer now moving to Haddr2.
	always_ff @(posedge Hclk)
	begin
		if (valid)
			Hwdata2 <= Hwdata;
		else if (Hreadyin)
			Hwdata1 <= Hwdata;   // data phase closes with no new transfer behind it.
	end

	// ----------------------------------------
	// response path
	// ----------------------------------------

	assign Hrdata = Prdata;   // read data is sampled by the master while Penable is high.
	assign Hresp = hrespOkay;

endmodule

`default_nettype wire

// File: bridgePkg.sv
`default_nettype none

package bridgePkg;

	localparam int addrWidth = 32;
	localparam int dataWidth = 32;
	localparam int numSlaves = 3;
	localparam int bankWords = 16;
	localparam int wordIdxWidth = $clog2(bankWords);

	typedef logic [addrWidth-1:0] addr_t;
	typedef logic [dataWidth-1:0] data_t;
	typedef logic [numSlaves-1:0] sel_t;

	localparam addr_t slave0Base = 32'h8000_0000;   // each peripheral owns a 64 MB window.
	localparam addr_t slave1Base = 32'h8400_0000;
	localparam addr_t slave2Base = 32'h8800_0000;
	localparam addr_t mapEnd = 32'h8C00_0000;       // first address past the map.

	localparam logic [1:0] htransIdle = 2'b00;
	localparam logic [1:0] htransBusy = 2'b01;
	localparam logic [1:0] htransNonseq = 2'b10;
	localparam logic [1:0] htransSeq = 2'b11;
	localparam logic [1:0] hrespOkay = 2'b00;

	typedef enum logic [2:0] {
		stIdle = 3'b000,
		stWwait = 3'b001,
		stRead = 3'b010,
		stWrite = 3'b011,
		stWriteP = 3'b100,
		stRenable = 3'b101,
		stWenable = 3'b110,
		stWenableP = 3'b111
	} apbState_t;

	// one-hot peripheral select, zero outside the map.
	function automatic sel_t selDecode(input addr_t addr);
		sel_t sel;
		sel = '0;
		if (addr >= slave0Base && addr < slave1Base)
			sel[0] = 1'b1;
		else if (addr >= slave1Base && addr < slave2Base)
			sel[1] = 1'b1;
		else if (addr >= slave2Base && addr < mapEnd)
			sel[2] = 1'b1;
		return sel;
	endfunction

endpackage

`default_nettype wire
